// File: sim.f
+incdir+include
hdl/cpu_pkg.sv
hdl/rf.sv
hdl/instr_port.sv
hdl/decode.sv
hdl/operand_bypass.sv
hdl/alu.sv
hdl/cpu_exec_top.sv
bench/clk_gen.sv
bench/tb_cpu_exec.sv

// File: Makefile
# verilator build and run of the execute core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_exec
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Simulation failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/tb_cpu_exec.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module tb_cpu_exec
  import cpu_pkg::*;
();

  localparam int WAIT_LIMIT = 50;   // cycles allowed per wait
  localparam int N_RANDOM   = 300;

  logic        hlt;
  logic        rst;
  logic        req;
  instr_t      instr;
  logic        ack;
  retire_t     retire;

  word_t       shadow [`CPU_NREGS];  // model register file
  flags_t      shadow_flags;
  retire_t     exp_q [$];            // expected retires, issue order
  int          ack_q [$];            // cycle at which each ack was seen
  logic [31:0] lfsr;
  int          cycle;
  int          errors;
  int          timeouts;
  int          retired;
  retire_t     got_exp;
  int          got_ack;

  clk_gen u_clk (.hlt(hlt), .rst(rst));

  cpu_exec_top dut_i (
    .hlt    (hlt),
    .rst    (rst),
    .req    (req),
    .instr  (instr),
    .ack    (ack),
    .retire (retire)
  );

  always @(posedge hlt) cycle <= cycle + 1;  // free-running edge count

  ////////////////////
  // helpers
  ////////////////////
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  function automatic instr_t make_instr(input logic [3:0] op, input reg_addr_t d,
                                        input reg_addr_t s1, input reg_addr_t s2);
    return {op, d, s1, s2};
  endfunction

  function automatic instr_t make_imm(input logic [3:0] op, input reg_addr_t d,
                                      input logic [7:0] imm);
    return {op, d, imm};
  endfunction

  // expected retire for one instruction against the model state
  function automatic retire_t predict_retire(input instr_t ins,
                                             input word_t regs [`CPU_NREGS],
                                             input flags_t flg);
    word_t      a;
    word_t      b;
    word_t      res;
    logic [7:0] imm;
    logic       sat;
    logic       known;
    int         sum;
    int         amt;
    int         i;
    retire_t    r;
    a     = regs[ins.src1];
    b     = regs[ins.src2];
    imm   = {ins.src1, ins.src2};
    amt   = int'(ins.src2);
    res   = '0;
    sat   = 1'b0;
    known = 1'b1;
    case (ins.opcode)
      OP_ADD, OP_SUB: begin
        if (ins.opcode == OP_ADD) sum = int'($signed(a)) + int'($signed(b));
        else                      sum = int'($signed(a)) - int'($signed(b));
        if (sum > 32767) begin
          res = 16'h7fff;  // clamp high
          sat = 1'b1;
        end else if (sum < -32768) begin
          res = 16'h8000;  // clamp low
          sat = 1'b1;
        end else begin
          res = sum[15:0];
        end
      end
      OP_AND: res = a & b;
      OP_NOR: res = ~(a | b);
      OP_SLL: res = a << amt;
      OP_SRL, OP_SRA: begin
        for (i = 0; i < 16; i++) begin
          res[i] = (i + amt < 16) ? a[i + amt] : (ins.opcode == OP_SRA && a[15]);
        end
      end
      OP_LLB: res = {{8{imm[7]}}, imm};
      OP_LHB: res = {imm, regs[ins.dst][7:0]};  // low byte of old dst
      default: known = 1'b0;                    // nop
    endcase
    r.valid = 1'b1;
    r.dst   = (known && ins.dst != '0) ? ins.dst : '0;
    r.data  = res;
    if (known && ins.opcode <= 4'd6) r.flags = '{z: (res == '0), v: sat, n: res[15]};
    else                             r.flags = flg;  // flags hold
    return r;
  endfunction

  // four-phase transfer of one word, model updated once ack is seen
  task automatic issue(input instr_t ins);
    int      n;
    logic    seen;
    retire_t exp;
    if (timeouts != 0) return;  // port already stuck
    instr <= ins;
    req   <= 1'b1;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < WAIT_LIMIT) begin
      @(posedge hlt);
      n++;
      seen = ack;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout at %0t: ack never came for instruction %h", $time, ins);
      return;
    end
    exp = predict_retire(ins, shadow, shadow_flags);
    if (exp.dst != '0)
      shadow[exp.dst] = exp.data;
    shadow_flags = exp.flags;
    exp_q.push_back(exp);
    ack_q.push_back(cycle);
    req <= 1'b0;
    n = 0;
    while (seen && n < WAIT_LIMIT) begin
      @(posedge hlt);
      n++;
      seen = ack;
    end
    if (seen) begin
      timeouts++;
      $display("timeout at %0t: ack stayed high after req dropped", $time);
    end
  endtask

  task automatic load_const(input reg_addr_t d, input word_t v);
    issue(make_imm(OP_LLB, d, v[7:0]));
    issue(make_imm(OP_LHB, d, v[15:8]));
  endtask

  task automatic log_mismatch(input string what, input logic [31:0] exp,
                              input logic [31:0] got);
    errors++;
    $display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp, got);
  endtask

  ////////////////////
  // retire checker
  ////////////////////
  always @(posedge hlt) begin
    if (!rst && retire.valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("retire at %0t with no instruction outstanding", $time);
      end else begin
        got_exp = exp_q.pop_front();
        got_ack = ack_q.pop_front();
        retired++;
        assert (retire.dst == got_exp.dst)
          else log_mismatch("retire dst", got_exp.dst, retire.dst);
        assert (retire.data == got_exp.data)
          else log_mismatch("retire data", got_exp.data, retire.data);
        assert (retire.flags == got_exp.flags)
          else log_mismatch("retire flags", got_exp.flags, retire.flags);
        assert (cycle - got_ack == `CPU_PIPE_LAT)
          else log_mismatch("cycles ack to retire", `CPU_PIPE_LAT, cycle - got_ack);
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    int          n;
    logic [15:0] r;
    req          <= 1'b0;
    instr        <= '0;
    lfsr         = 32'hb0141dc3;
    shadow_flags = '0;
    foreach (shadow[i]) shadow[i] = '0;
    n = 0;
    do begin
      @(posedge hlt);
      n++;
    end while (rst && n < WAIT_LIMIT);
    if (rst) begin
      timeouts++;
      $display("timeout: reset never released");
    end

    // constants, llb then lhb
    load_const(4'd1, 16'h1234);
    load_const(4'd2, 16'h8001);
    load_const(4'd3, 16'h7ffe);
    load_const(4'd4, 16'h00ff);
    load_const(4'd5, 16'h7fff);
    load_const(4'd6, 16'h8000);
    load_const(4'd7, 16'h0001);

    // saturation both ways
    issue(make_instr(OP_ADD, 4'd8, 4'd5, 4'd7));   // 7fff + 1
    issue(make_instr(OP_ADD, 4'd8, 4'd6, 4'd2));   // 8000 + 8001
    issue(make_instr(OP_SUB, 4'd9, 4'd6, 4'd7));   // 8000 - 1
    issue(make_instr(OP_SUB, 4'd9, 4'd5, 4'd6));   // 7fff - 8000
    issue(make_instr(OP_SUB, 4'd10, 4'd1, 4'd1));  // z set
    issue(make_instr(OP_ADD, 4'd10, 4'd1, 4'd2));  // mixed signs, n set

    // logic and shifts
    issue(make_instr(OP_AND, 4'd11, 4'd1, 4'd4));
    issue(make_instr(OP_NOR, 4'd11, 4'd1, 4'd4));
    issue(make_instr(OP_SLL, 4'd12, 4'd1, 4'd4));
    issue(make_instr(OP_SRL, 4'd12, 4'd2, 4'd3));
    issue(make_instr(OP_SRA, 4'd12, 4'd2, 4'd3));  // sign fill
    issue(make_instr(OP_SRA, 4'd13, 4'd1, 4'd15));
    issue(make_instr(OP_SLL, 4'd13, 4'd5, 4'd15));

    // dependent chain on r14
    issue(make_imm(OP_LLB, 4'd14, 8'h03));
    for (int k = 0; k < 4; k++) begin
      issue(make_instr(OP_ADD, 4'd14, 4'd14, 4'd14));
    end
    issue(make_instr(OP_SUB, 4'd14, 4'd14, 4'd14));
    issue(make_imm(OP_LHB, 4'd14, 8'h5a));
    issue(make_instr(OP_NOR, 4'd14, 4'd14, 4'd14));

    // r0 targets and nops
    issue(make_instr(OP_ADD, 4'd0, 4'd1, 4'd1));
    issue(make_imm(OP_LLB, 4'd0, 8'h55));
    issue(make_imm(OP_LHB, 4'd0, 8'haa));
    issue(make_instr(4'd7, 4'd3, 4'd1, 4'd2));
    issue(make_instr(4'd12, 4'd4, 4'd4, 4'd4));
    issue(make_instr(4'd15, 4'd5, 4'd0, 4'd0));
    issue(make_instr(OP_ADD, 4'd15, 4'd0, 4'd0));  // r0 reads zero
    issue(make_instr(OP_AND, 4'd15, 4'd3, 4'd3));  // r3 untouched by nop

    // random words, nop codes included
    for (int k = 0; k < N_RANDOM; k++) begin
      draw_bits(16, r);
      issue(instr_t'(r));
    end

    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      @(posedge hlt);
      n++;
    end
    if (exp_q.size() != 0) begin
      timeouts++;
      $display("timeout: %0d retires never arrived", exp_q.size());
    end
    repeat (`CPU_PIPE_LAT + 2) @(posedge hlt);  // room for a stray retire
    assert (exp_q.size() == 0 && !retire.valid) else begin
      errors++;
      $display("retire still pending at the end of the run");
    end

    $display("summary: %0d retired, %0d errors, %0d timeouts", retired, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int HALF_NS    = 50,  // 100 ns period
  parameter int RST_CYCLES = 8
) (
  output logic hlt,
  output logic rst
);

  initial begin
    hlt = 1'b0;
    forever #(HALF_NS) hlt = ~hlt;
  end

  // sync reset, released on an edge
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge hlt);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// File: hdl/cpu_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_exec_top
  import cpu_pkg::*;
(
  input  logic    hlt,
  input  logic    rst,
  input  logic    req,     // four-phase instruction request
  input  instr_t  instr,
  output logic    ack,
  output retire_t retire   // one pulse per instruction, in order
);

  ////////////////////
  // stage wiring
  ////////////////////
  logic       cap_valid;  // capture pulse, E0
  instr_t     cap_instr;
  reg_addr_t  rd0_addr;
  reg_addr_t  rd1_addr;
  ctrl_t      ctrl;       // decode register, E1
  word_t      rd0;
  word_t      rd1;
  word_t      opa;        // bypassed operands
  word_t      opb;
  stage_res_t ex_res;     // E2 result, also the rf write
  stage_res_t wb_res;     // E3 copy

  instr_port u_instr_port (
    .hlt       (hlt),
    .rst       (rst),
    .req       (req),
    .instr     (instr),
    .ack       (ack),
    .cap_valid (cap_valid),
    .cap_instr (cap_instr)
  );

  decode u_decode (
    .hlt       (hlt),
    .rst       (rst),
    .cap_valid (cap_valid),
    .cap_instr (cap_instr),
    .rd0_addr  (rd0_addr),
    .rd1_addr  (rd1_addr),
    .ctrl      (ctrl)
  );

  rf u_rf (
    .hlt      (hlt),
    .rst      (rst),
    .rd0_addr (rd0_addr),
    .rd1_addr (rd1_addr),
    .rd0      (rd0),
    .rd1      (rd1),
    .wr       (ex_res)     // written at E3
  );

  operand_bypass u_bypass (
    .ctrl   (ctrl),
    .rd0    (rd0),
    .rd1    (rd1),
    .ex_res (ex_res),
    .wb_res (wb_res),
    .opa    (opa),
    .opb    (opb)
  );

  alu u_alu (
    .hlt    (hlt),
    .rst    (rst),
    .ctrl   (ctrl),
    .opa    (opa),
    .opb    (opb),
    .ex_res (ex_res),
    .wb_res (wb_res),
    .retire (retire)
  );

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
  import cpu_pkg::*;
(
  input  logic       hlt,
  input  logic       rst,
  input  ctrl_t      ctrl,
  input  word_t      opa,
  input  word_t      opb,
  output stage_res_t ex_res,  // to rf write port and bypass
  output stage_res_t wb_res,  // write-back copy for the bypass
  output retire_t    retire
);

  localparam int    MSB     = $bits(word_t) - 1;
  localparam word_t SAT_POS = 16'h7fff;
  localparam word_t SAT_NEG = 16'h8000;

  word_t     add_raw, sub_raw, sat_val, res;
  logic      add_ovf, sub_ovf, sat;
  flags_t    flags_d, flags_q, ret_flags;
  logic      ex_vld, ex_wr, wb_vld, ret_vld;
  reg_addr_t ex_dst, wb_dst;
  word_t     ex_data, wb_data;

  assign add_raw = opa + opb;
  assign sub_raw = opa - opb;
  assign add_ovf = (opa[MSB] == opb[MSB]) && (add_raw[MSB] != opa[MSB]);
  assign sub_ovf = (opa[MSB] != opb[MSB]) && (sub_raw[MSB] != opa[MSB]);
  assign sat_val = opa[MSB] ? SAT_NEG : SAT_POS;  // clamp toward the sign of a

  always_comb begin
    res = '0;  // nop
    sat = 1'b0;
    case (ctrl.op)
      OP_ADD: begin
        sat = add_ovf;
        res = add_ovf ? sat_val : add_raw;
      end
      OP_SUB: begin
        sat = sub_ovf;
        res = sub_ovf ? sat_val : sub_raw;
      end
      OP_AND:  res = opa & opb;
      OP_NOR:  res = ~(opa | opb);
      OP_SLL:  res = opa << ctrl.src2;
      OP_SRL:  res = opa >> ctrl.src2;
      OP_SRA:  res = word_t'($signed(opa) >>> ctrl.src2);  // sign fill
      OP_LLB:  res = {{8{ctrl.imm8[7]}}, ctrl.imm8};
      OP_LHB:  res = {ctrl.imm8, opa[7:0]};  // opa holds old dst
      default: res = '0;
    endcase
    flags_d = '{z: (res == '0), v: sat, n: res[MSB]};
  end

  ////////////////////
  // execute and write-back
  ////////////////////
  always_ff @(posedge hlt) begin
    if (rst) begin
      {ex_vld, ex_wr, wb_vld, ret_vld} <= '0;
      flags_q <= '0;
    end else begin
      ex_vld  <= ctrl.valid;                     // E2
      ex_wr   <= ctrl.valid && ctrl.writes_reg;
      wb_vld  <= ex_wr;                          // E3
      ret_vld <= ex_vld;
      if (ctrl.valid && ctrl.sets_flags) begin
        flags_q <= flags_d;
      end
    end
  end

  always_ff @(posedge hlt) begin
    if (ctrl.valid) begin
      ex_dst  <= ctrl.writes_reg ? ctrl.dst : '0;  // non-writers retire as r0
      ex_data <= res;
    end
    if (ex_vld) begin
      wb_dst    <= ex_dst;
      wb_data   <= ex_data;
      ret_flags <= flags_q;
    end
  end

  assign ex_res = '{valid: ex_wr, dst: ex_dst, data: ex_data};
  assign wb_res = '{valid: wb_vld, dst: wb_dst, data: wb_data};
  assign retire = '{valid: ret_vld, dst: wb_dst, data: wb_data, flags: ret_flags};

  // each retire maps to one decoded instruction two edges back, never back to back
  a_one_retire: assert property (
    @(posedge hlt) disable iff (rst)
    retire.valid |-> ($past(ctrl.valid, 2) && !$past(retire.valid))
  );

endmodule

`default_nettype wire

// File: hdl/operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module operand_bypass
  import cpu_pkg::*;
(
  input  ctrl_t      ctrl,
  input  word_t      rd0,     // rf read, registered at E1
  input  word_t      rd1,
  input  stage_res_t ex_res,  // result sitting in the execute register
  input  stage_res_t wb_res,  // result one stage older
  output word_t      opa,
  output word_t      opb
);

  // newest source wins, so ex is checked after wb
  function automatic word_t pick(input reg_addr_t  addr,
                                 input word_t      rf_word,
                                 input stage_res_t ex,
                                 input stage_res_t wb);
    word_t val;
    val = rf_word;
    if (addr != '0) begin  // r0 is always zero
      if (wb.valid && (wb.dst == addr)) begin
        val = wb.data;  // rf read was taken before this write
      end
      if (ex.valid && (ex.dst == addr)) begin
        val = ex.data;
      end
    end
    return val;
  endfunction

  assign opa = pick(ctrl.src1, rd0, ex_res, wb_res);
  assign opb = pick(ctrl.src2, rd1, ex_res, wb_res);  // unused by shifts and loads

endmodule

`default_nettype wire

// File: hdl/decode.sv
`timescale 1ns/1ps
`default_nettype none

module decode
  import cpu_pkg::*;
(
  input  logic      hlt,
  input  logic      rst,
  input  logic      cap_valid,
  input  instr_t    cap_instr,
  output reg_addr_t rd0_addr,  // straight to rf, lines up with ctrl at E1
  output reg_addr_t rd1_addr,
  output ctrl_t     ctrl
);

  ctrl_t ctrl_d;
  logic  known;  // opcode is one of the defined ops

  // lhb needs old dst contents to keep the low byte
  assign rd0_addr = (cap_instr.opcode == OP_LHB) ? cap_instr.dst : cap_instr.src1;
  assign rd1_addr = cap_instr.src2;

  always_comb begin
    case (cap_instr.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_NOR,
      OP_SLL, OP_SRL, OP_SRA,
      OP_LLB, OP_LHB: known = 1'b1;
      default:        known = 1'b0;
    endcase
  end

  always_comb begin
    ctrl_d            = '0;
    ctrl_d.valid      = cap_valid;
    ctrl_d.op         = known ? opcode_e'(cap_instr.opcode) : OP_NOP;
    ctrl_d.dst        = cap_instr.dst;
    ctrl_d.src1       = rd0_addr;  // bypass compares the real read address
    ctrl_d.src2       = cap_instr.src2;
    ctrl_d.imm8       = {cap_instr.src1, cap_instr.src2};
    ctrl_d.writes_reg = known && (cap_instr.dst != '0);  // r0 and nop write nothing
    ctrl_d.sets_flags = known && (cap_instr.opcode <= OP_SRA);
  end

  ////////////////////
  // decode register
  ////////////////////
  always_ff @(posedge hlt) begin
    if (rst) begin
      ctrl <= '0;
    end else if (cap_valid) begin
      ctrl <= ctrl_d;
    end else begin
      ctrl.valid <= 1'b0;  // single-cycle valid, fields hold
    end
  end

endmodule

`default_nettype wire

// File: hdl/instr_port.sv
`timescale 1ns/1ps
`default_nettype none

module instr_port
  import cpu_pkg::*;
(
  input  logic   hlt,
  input  logic   rst,
  input  logic   req,        // four-phase request from outside
  input  instr_t instr,
  output logic   ack,
  output logic   cap_valid,  // one pulse per transfer
  output instr_t cap_instr   // held until the next transfer
);

  port_state_e state;
  port_state_e state_nxt;
  logic        take;  // capture this edge

  always_comb begin
    state_nxt = state;
    take      = 1'b0;
    case (state)
      IDLE: begin
        if (req) begin
          take      = 1'b1;  // grab the word and raise ack
          state_nxt = ACKED;
        end
      end
      ACKED: begin
        state_nxt = req ? WAIT_REQ_LOW : IDLE;
      end
      WAIT_REQ_LOW: begin
        if (!req) begin
          state_nxt = IDLE;  // ack falls here
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge hlt) begin
    if (rst) begin
      state     <= IDLE;
      cap_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      cap_valid <= take;
    end
  end

  always_ff @(posedge hlt) begin
    if (take) begin
      cap_instr <= instr;
    end
  end

  assign ack = (state != IDLE);  // state is registered, so ack is too

  // an ack edge must answer a request seen high on that same edge
  a_ack_needs_req: assert property (
    @(posedge hlt) disable iff (rst)
    $rose(ack) |-> $past(req)
  );

endmodule

`default_nettype wire

// File: hdl/rf.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module rf
  import cpu_pkg::*;
(
  input  logic       hlt,
  input  logic       rst,
  input  reg_addr_t  rd0_addr,  // first source
  input  reg_addr_t  rd1_addr,  // second source
  output word_t      rd0,
  output word_t      rd1,
  input  stage_res_t wr         // from the execute register
);

  word_t mem [`CPU_NREGS];
  logic  wr_hit0;  // write-through onto port 0
  logic  wr_hit1;  // write-through onto port 1
  logic  wr_en;

  assign wr_en   = wr.valid && (wr.dst != '0);  // r0 never written
  assign wr_hit0 = wr_en && (wr.dst == rd0_addr);
  assign wr_hit1 = wr_en && (wr.dst == rd1_addr);

  ////////////////////
  // write port
  ////////////////////
  always_ff @(posedge hlt) begin
    if (rst) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        mem[i] <= '0;  // all regs come up zero
      end
    end else if (wr_en) begin
      mem[wr.dst] <= wr.data;
    end
  end

  ////////////////////
  // read ports
  ////////////////////
  // one edge of latency, newest write wins
  always_ff @(posedge hlt) begin
    rd0 <= wr_hit0 ? wr.data : mem[rd0_addr];
    rd1 <= wr_hit1 ? wr.data : mem[rd1_addr];
  end

  // decode clears writes_reg for dst 0, so alu must never present one
  a_no_r0_write: assert property (
    @(posedge hlt) disable iff (rst)
    wr.valid |-> (wr.dst != '0)
  );

endmodule

`default_nettype wire

// File: hdl/cpu_pkg.sv
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

  typedef logic [`CPU_DATA_W-1:0] word_t;      // one data word
  typedef logic [`CPU_ADDR_W-1:0] reg_addr_t;  // register index

  // opcode encodings, unlisted values decode as nop
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,   // saturating
    OP_SUB = 4'd1,   // saturating
    OP_AND = 4'd2,
    OP_NOR = 4'd3,
    OP_SLL = 4'd4,
    OP_SRL = 4'd5,
    OP_SRA = 4'd6,
    OP_LLB = 4'd10,  // sign-extended low byte
    OP_LHB = 4'd11,  // high byte, low byte kept
    OP_NOP = 4'd15   // internal code for anything unknown
  } opcode_e;

  typedef enum logic [1:0] {IDLE, ACKED, WAIT_REQ_LOW} port_state_e;

  typedef struct packed {
    logic [3:0] opcode;
    reg_addr_t  dst;
    reg_addr_t  src1;  // imm8[7:4] for llb/lhb
    reg_addr_t  src2;  // shift amount or imm8[3:0]
  } instr_t;

  typedef struct packed {
    logic z;
    logic v;  // saturation seen on add/sub
    logic n;
  } flags_t;

  typedef struct packed {
    logic      valid;
    opcode_e   op;
    reg_addr_t dst;
    reg_addr_t src1;        // effective read address, dst for lhb
    reg_addr_t src2;
    logic [7:0] imm8;
    logic      writes_reg;  // known op with nonzero dst
    logic      sets_flags;  // ops 0..6
  } ctrl_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    word_t     data;
  } stage_res_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t dst;
    word_t     data;
    flags_t    flags;
  } retire_t;

endpackage

`default_nettype wire

// File: include/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

////////////////////
// datapath sizing
////////////////////

// width of one register / alu word
`define CPU_DATA_W    16

// architectural registers, r0 reads as zero
`define CPU_NREGS     16

// bits needed to index CPU_NREGS
`define CPU_ADDR_W    4

////////////////////
// pipeline timing
////////////////////

// edges from ack rising to retire valid
`define CPU_PIPE_LAT  3

`endif
